/* hw/dvi_fmt_defines.svh */
`ifndef DVI_FMT_DEFINES_SVH
`define DVI_FMT_DEFINES_SVH

////////////////////////////////////////
// Widths
////////////////////////////////////////

`define HV_W 11 // Raster counts and thresholds
`define DCM_W 8 // Synthesizer M and D factors
`define SW_W 4 // Format switches

////////////////////////////////////////
// Control timing
////////////////////////////////////////

// Stable cycles before a switch setting counts
`define DEBOUNCE_LEN 16
`define GO_DELAY 16 // Acceptance to synthesizer go

`endif

/* hw/video_fmt_pkg.sv */
`default_nettype none

`include "dvi_fmt_defines.svh"

package video_fmt_pkg;

	////////////////////////////////////////
	// Format switch codes
	////////////////////////////////////////

	typedef enum logic [`SW_W-1:0] {
		FMT_VGA      = 4'b0000, // 640x480
		FMT_SVGA     = 4'b0001, // 800x600
		FMT_HDTV720P = 4'b0010, // 1280x720, also any unlisted code
		FMT_XGA      = 4'b0011, // 1024x768
		FMT_SXGA     = 4'b1000, // 1280x1024
		FMT_CAMERA   = 4'b1001  // 1280x720 camera raster
	} fmt_sw_t;

	// Raster position or threshold, pixels or lines
	typedef logic [`HV_W-1:0] hv_cnt_t;

endpackage

`default_nettype wire

/* hw/pclk_cfg_pkg.sv */
`default_nettype none

`include "dvi_fmt_defines.svh"

package pclk_cfg_pkg;

	// Pixel clock synthesizer factor
	// Held as the wanted value minus one
	typedef logic [`DCM_W-1:0] dcm_factor_t;

endpackage

`default_nettype wire

/* hw/sw_debounce.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dvi_fmt_defines.svh"

module sw_debounce (
	input  logic                    clk50m_bufg,
	input  logic                    RSTBTN,
	input  logic [`SW_W-1:0]        sw, // Asynchronous switches
	output video_fmt_pkg::fmt_sw_t  fmt, // Accepted setting
	output logic                    fmt_change // One cycle on acceptance
);

	localparam int CNT_W = $clog2(`DEBOUNCE_LEN + 1);

	logic [`SW_W-1:0] sw_meta; // First synchronizer stage
	logic [`SW_W-1:0] sw_sync; // Second stage
	logic [`SW_W-1:0] sw_q; // Value under test
	logic [CNT_W-1:0] stable_cnt;
	logic seen; // Some setting accepted since reset
	logic stable_hit;

	////////////////////////////////////////
	// Synchronizer and holding register
	////////////////////////////////////////

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			sw_meta <= '0;
			sw_sync <= '0;
			sw_q    <= '0;
		end else begin
			sw_meta <= sw;
			sw_sync <= sw_meta;
			sw_q    <= sw_sync;
		end
	end

	// Last stable cycle, value still held, and it is news
	assign stable_hit = (stable_cnt == CNT_W'(`DEBOUNCE_LEN - 1)) &&
		(sw_sync == sw_q) && (!seen || (sw_q != fmt));

	////////////////////////////////////////
	// Stability count and acceptance
	////////////////////////////////////////

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			stable_cnt <= '0;
			seen       <= 1'b0;
			fmt        <= video_fmt_pkg::FMT_VGA;
			fmt_change <= 1'b0;
		end else begin
			if (sw_sync != sw_q)
				stable_cnt <= '0; // sw_q moves next cycle
			else if (stable_cnt != CNT_W'(`DEBOUNCE_LEN))
				stable_cnt <= stable_cnt + 1'b1; // Saturates, so one hit per value
			fmt_change <= stable_hit;
			if (stable_hit) begin
				fmt  <= video_fmt_pkg::fmt_sw_t'(sw_q);
				seen <= 1'b1; // Power-up setting accepted once
			end
		end
	end

endmodule

`default_nettype wire

/* hw/pclk_ratio_sel.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dvi_fmt_defines.svh"

module pclk_ratio_sel (
	input  logic                        clk50m_bufg,
	input  logic                        RSTBTN,
	input  video_fmt_pkg::fmt_sw_t      fmt,
	input  logic                        fmt_change,
	output pclk_cfg_pkg::dcm_factor_t   pclk_m, // Multiply minus one
	output pclk_cfg_pkg::dcm_factor_t   pclk_d, // Divide minus one
	output logic                        pclk_go
);

	pclk_cfg_pkg::dcm_factor_t m_sel;
	pclk_cfg_pkg::dcm_factor_t d_sel;
	logic [`GO_DELAY-1:0] go_line; // One bit per delay cycle

	////////////////////////////////////////
	// Factor table, 50 MHz reference
	////////////////////////////////////////

	always_comb begin
		case (fmt)
			video_fmt_pkg::FMT_VGA: begin // 25 MHz
				m_sel = 8'd2 - 8'd1;
				d_sel = 8'd4 - 8'd1;
			end
			video_fmt_pkg::FMT_SVGA: begin // 40 MHz
				m_sel = 8'd4 - 8'd1;
				d_sel = 8'd5 - 8'd1;
			end
			video_fmt_pkg::FMT_XGA: begin // 65 MHz
				m_sel = 8'd13 - 8'd1;
				d_sel = 8'd10 - 8'd1;
			end
			video_fmt_pkg::FMT_SXGA: begin // 108 MHz
				m_sel = 8'd54 - 8'd1;
				d_sel = 8'd25 - 8'd1;
			end
			video_fmt_pkg::FMT_CAMERA: begin
				m_sel = 8'd135 - 8'd1;
				d_sel = 8'd91 - 8'd1;
			end
			default: begin // 74.25 MHz, 720p and unknown codes
				m_sel = 8'd248 - 8'd1;
				d_sel = 8'd167 - 8'd1;
			end
		endcase
	end

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			pclk_m  <= '0;
			pclk_d  <= '0;
			go_line <= '0;
		end else begin
			if (fmt_change) begin
				pclk_m <= m_sel;
				pclk_d <= d_sel;
			end
			// Shift line lets back-to-back changes each get a go
			go_line <= {go_line[`GO_DELAY-2:0], fmt_change};
		end
	end

	assign pclk_go = go_line[`GO_DELAY-1]; // GO_DELAY cycles after fmt_change

endmodule

`default_nettype wire

/* hw/video_timing_sel.sv */
`timescale 1ns/100ps
`default_nettype none

module video_timing_sel (
	input  video_fmt_pkg::fmt_sw_t  fmt,
	output video_fmt_pkg::hv_cnt_t  tc_hsblnk, // Last live pixel
	output video_fmt_pkg::hv_cnt_t  tc_hssync,
	output video_fmt_pkg::hv_cnt_t  tc_hesync,
	output video_fmt_pkg::hv_cnt_t  tc_heblnk, // Last pixel of line
	output video_fmt_pkg::hv_cnt_t  tc_vsblnk, // Last live line
	output video_fmt_pkg::hv_cnt_t  tc_vssync,
	output video_fmt_pkg::hv_cnt_t  tc_vesync,
	output video_fmt_pkg::hv_cnt_t  tc_veblnk, // Last line of frame
	output logic                    sync_neg // 1 = active low syncs
);

	video_fmt_pkg::hv_cnt_t h_live, h_fp, h_sw, h_bp;
	video_fmt_pkg::hv_cnt_t v_live, v_fp, v_sw, v_bp;

	////////////////////////////////////////
	// Raster table
	////////////////////////////////////////

	// Live / front porch / sync / back porch
	always_comb begin
		case (fmt)
			video_fmt_pkg::FMT_VGA: begin
				h_live = 11'd640;
				h_fp   = 11'd16;
				h_sw   = 11'd96;
				h_bp   = 11'd48;
				v_live = 11'd480;
				v_fp   = 11'd11;
				v_sw   = 11'd2;
				v_bp   = 11'd31;
				sync_neg = 1'b1;
			end
			video_fmt_pkg::FMT_SVGA: begin
				h_live = 11'd800;
				h_fp   = 11'd40;
				h_sw   = 11'd128;
				h_bp   = 11'd88;
				v_live = 11'd600;
				v_fp   = 11'd1;
				v_sw   = 11'd4;
				v_bp   = 11'd23;
				sync_neg = 1'b0;
			end
			video_fmt_pkg::FMT_XGA: begin
				h_live = 11'd1024;
				h_fp   = 11'd24;
				h_sw   = 11'd136;
				h_bp   = 11'd160;
				v_live = 11'd768;
				v_fp   = 11'd3;
				v_sw   = 11'd6;
				v_bp   = 11'd29;
				sync_neg = 1'b1;
			end
			video_fmt_pkg::FMT_SXGA: begin
				h_live = 11'd1280;
				h_fp   = 11'd48;
				h_sw   = 11'd112;
				h_bp   = 11'd248;
				v_live = 11'd1024;
				v_fp   = 11'd1;
				v_sw   = 11'd3;
				v_bp   = 11'd38;
				sync_neg = 1'b0;
			end
			video_fmt_pkg::FMT_CAMERA: begin // Shorter sync than 720p
				h_live = 11'd1280;
				h_fp   = 11'd110;
				h_sw   = 11'd39;
				h_bp   = 11'd220;
				v_live = 11'd720;
				v_fp   = 11'd4;
				v_sw   = 11'd4;
				v_bp   = 11'd22;
				sync_neg = 1'b0;
			end
			default: begin // 720p
				h_live = 11'd1280;
				h_fp   = 11'd110;
				h_sw   = 11'd40;
				h_bp   = 11'd220;
				v_live = 11'd720;
				v_fp   = 11'd5;
				v_sw   = 11'd5;
				v_bp   = 11'd20;
				sync_neg = 1'b0;
			end
		endcase
	end

	// Thresholds are running sums, counters start at 0
	assign tc_hsblnk = h_live - 11'd1;
	assign tc_hssync = tc_hsblnk + h_fp;
	assign tc_hesync = tc_hssync + h_sw;
	assign tc_heblnk = tc_hesync + h_bp;

	assign tc_vsblnk = v_live - 11'd1;
	assign tc_vssync = tc_vsblnk + v_fp;
	assign tc_vesync = tc_vssync + v_sw;
	assign tc_veblnk = tc_vesync + v_bp;

endmodule

`default_nettype wire

/* hw/timing_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module timing_gen (
	input  logic                    clk50m_bufg,
	input  logic                    RSTBTN,
	input  logic                    restart, // Format change zeroes the counters
	input  video_fmt_pkg::hv_cnt_t  tc_hsblnk,
	input  video_fmt_pkg::hv_cnt_t  tc_hssync,
	input  video_fmt_pkg::hv_cnt_t  tc_hesync,
	input  video_fmt_pkg::hv_cnt_t  tc_heblnk,
	input  video_fmt_pkg::hv_cnt_t  tc_vsblnk,
	input  video_fmt_pkg::hv_cnt_t  tc_vssync,
	input  video_fmt_pkg::hv_cnt_t  tc_vesync,
	input  video_fmt_pkg::hv_cnt_t  tc_veblnk,
	input  logic                    sync_neg,
	output logic                    hsync,
	output logic                    vsync,
	output logic                    de
);

	logic en; // Raster running
	video_fmt_pkg::hv_cnt_t hcount;
	video_fmt_pkg::hv_cnt_t vcount;
	logic h_end; // Last pixel of line
	logic v_end;
	logic hsync_raw, vsync_raw, de_raw;

	// Wrap points of the raster
	assign h_end = (hcount >= tc_heblnk);
	assign v_end = (vcount >= tc_veblnk);

	////////////////////////////////////////
	// Raster counters
	////////////////////////////////////////

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			en     <= 1'b0;
			hcount <= '0;
			vcount <= '0;
		end else if (restart) begin
			en     <= 1'b1; // First restart starts the raster
			hcount <= '0;
			vcount <= '0;
		end else if (en) begin
			if (h_end) begin
				hcount <= '0;
				if (v_end)
					vcount <= '0;
				else
					vcount <= vcount + 1'b1;
			end else begin
				hcount <= hcount + 1'b1;
			end
		end
	end

	// Sync pulse just past the front porch
	assign hsync_raw = (hcount > tc_hssync) && (hcount <= tc_hesync);
	assign vsync_raw = (vcount > tc_vssync) && (vcount <= tc_vesync);
	assign de_raw = (hcount <= tc_hsblnk) && (vcount <= tc_vsblnk);

	////////////////////////////////////////
	// Output registers one cycle behind
	////////////////////////////////////////

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			hsync <= sync_neg; // Idle level
			vsync <= sync_neg;
			de    <= 1'b0;
		end else if (!en) begin
			hsync <= sync_neg;
			vsync <= sync_neg;
			de    <= 1'b0;
		end else begin
			hsync <= hsync_raw ^ sync_neg;
			vsync <= vsync_raw ^ sync_neg;
			de    <= de_raw;
		end
	end

endmodule

`default_nettype wire

/* hw/dvi_fmt_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dvi_fmt_defines.svh"

module dvi_fmt_ctrl (
	input  logic                        clk50m_bufg,
	input  logic                        RSTBTN,
	input  logic [`SW_W-1:0]            sw, // Format switches, async
	output pclk_cfg_pkg::dcm_factor_t   pclk_m,
	output pclk_cfg_pkg::dcm_factor_t   pclk_d,
	output logic                        pclk_go, // Start synthesizer programming
	output logic                        hsync,
	output logic                        vsync,
	output logic                        de
);

	video_fmt_pkg::fmt_sw_t fmt;
	logic fmt_change;
	video_fmt_pkg::hv_cnt_t tc_hsblnk, tc_hssync, tc_hesync, tc_heblnk;
	video_fmt_pkg::hv_cnt_t tc_vsblnk, tc_vssync, tc_vesync, tc_veblnk;
	logic sync_neg;

	////////////////////////////////////////
	// Switch input
	////////////////////////////////////////

	sw_debounce u_sw_debounce (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw          (sw),
		.fmt         (fmt),
		.fmt_change  (fmt_change)
	);

	// Synthesizer factors and go
	pclk_ratio_sel u_pclk_ratio_sel (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.fmt         (fmt),
		.fmt_change  (fmt_change),
		.pclk_m      (pclk_m),
		.pclk_d      (pclk_d),
		.pclk_go     (pclk_go)
	);

	////////////////////////////////////////
	// Raster timing
	////////////////////////////////////////

	video_timing_sel u_video_timing_sel (
		.fmt       (fmt),
		.tc_hsblnk (tc_hsblnk),
		.tc_hssync (tc_hssync),
		.tc_hesync (tc_hesync),
		.tc_heblnk (tc_heblnk),
		.tc_vsblnk (tc_vsblnk),
		.tc_vssync (tc_vssync),
		.tc_vesync (tc_vesync),
		.tc_veblnk (tc_veblnk),
		.sync_neg  (sync_neg)
	);

	timing_gen u_timing_gen (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.restart     (fmt_change), // New format restarts the frame
		.tc_hsblnk   (tc_hsblnk),
		.tc_hssync   (tc_hssync),
		.tc_hesync   (tc_hesync),
		.tc_heblnk   (tc_heblnk),
		.tc_vsblnk   (tc_vsblnk),
		.tc_vssync   (tc_vssync),
		.tc_vesync   (tc_vesync),
		.tc_veblnk   (tc_veblnk),
		.sync_neg    (sync_neg),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de)
	);

endmodule

`default_nettype wire

/* tests/tb_dvi_fmt_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dvi_fmt_defines.svh"

module tb_dvi_fmt_ctrl;

	localparam int BOUNCE_STEPS = 12;
	localparam int SWITCH_CYC = 4 + `DEBOUNCE_LEN + 8; // Sync stages, debounce, slack
	localparam int SETTLE_CYC = `GO_DELAY + 4; // Go pulse plus a few idle cycles
	localparam int VGA_FRAME = 800 * 525;
	localparam int SVGA_FRAME = 1056 * 628;
	localparam int RUN_LIMIT = VGA_FRAME + SVGA_FRAME + 4 * 1650 +
		16 * (SWITCH_CYC + SETTLE_CYC) + 4 * BOUNCE_STEPS * `DEBOUNCE_LEN + 20000;

	// Expected raster and synthesizer values of one format
	typedef struct packed {
		int h_total;
		int h_live;
		int h_sync;
		int v_total;
		int v_live;
		int v_fp;
		int v_sync;
		int m;
		int d;
		bit neg;
	} fmt_ref_t;

	logic clk50m_bufg = 1'b0;
	logic RSTBTN;
	logic [`SW_W-1:0] sw;
	pclk_cfg_pkg::dcm_factor_t pclk_m;
	pclk_cfg_pkg::dcm_factor_t pclk_d;
	logic pclk_go, hsync, vsync, de;

	int cyc = 0; // Posedge count for watchdog and go timing
	int errors = 0;
	int err_at_start = 0;
	int tests_run = 0;
	int tests_failed = 0;
	string test_name = "reset";
	int go_count = 0;
	int de_count = 0;
	int sync_moves = 0; // Sync level changes outside reset
	int chg_cyc = 0; // Cycle of last factor change
	logic [2*`DCM_W-1:0] fac_prev = '0;
	logic hs_last = 1'b0, vs_last = 1'b0;

	dvi_fmt_ctrl dut (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw          (sw),
		.pclk_m      (pclk_m),
		.pclk_d      (pclk_d),
		.pclk_go     (pclk_go),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de)
	);

	always #10 clk50m_bufg = ~clk50m_bufg; // 50 MHz

	always @(posedge clk50m_bufg)
		cyc <= cyc + 1;

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic fmt_ref_t timing_entry(input int hl, hf, hs, hb,
		input int vl, vf, vs, vb, input int m, d, input bit neg);
		fmt_ref_t r;
		r.h_total = hl + hf + hs + hb; // Live, porches and sync
		r.h_live = hl;
		r.h_sync = hs;
		r.v_total = vl + vf + vs + vb;
		r.v_live = vl;
		r.v_fp = vf;
		r.v_sync = vs;
		r.m = m;
		r.d = d;
		r.neg = neg;
		return r;
	endfunction

	function automatic fmt_ref_t expected_format(input video_fmt_pkg::fmt_sw_t code);
		case (code)
			video_fmt_pkg::FMT_VGA:
				return timing_entry(640, 16, 96, 48, 480, 11, 2, 31, 2, 4, 1);
			video_fmt_pkg::FMT_SVGA:
				return timing_entry(800, 40, 128, 88, 600, 1, 4, 23, 4, 5, 0);
			video_fmt_pkg::FMT_XGA:
				return timing_entry(1024, 24, 136, 160, 768, 3, 6, 29, 13, 10, 1);
			video_fmt_pkg::FMT_SXGA:
				return timing_entry(1280, 48, 112, 248, 1024, 1, 3, 38, 54, 25, 0);
			video_fmt_pkg::FMT_CAMERA:
				return timing_entry(1280, 110, 39, 220, 720, 4, 4, 22, 135, 91, 0);
			default:
				return timing_entry(1280, 110, 40, 220, 720, 5, 5, 20, 248, 167, 0);
		endcase
	endfunction

	task automatic flag_mismatch(input string what, input int exp, input int act);
		$display("ERROR %s: %s expected %0d, actual %0d", test_name, what, exp, act);
		errors++;
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		err_at_start = errors;
	endtask

	task automatic end_test;
		tests_run++;
		if (errors == err_at_start) begin
			$display("%s: passed", test_name);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", test_name, errors - err_at_start);
		end
	endtask

	////////////////////////////////////////
	// Output monitor
	////////////////////////////////////////

	// Go pulse count and delay from the factor change
	always @(negedge clk50m_bufg) begin
		if (!RSTBTN) begin
			if ({pclk_m, pclk_d} !== fac_prev)
				chg_cyc = cyc; // fmt_change was one cycle before
			if (pclk_go) begin
				go_count++;
				if (cyc - chg_cyc + 1 != `GO_DELAY)
					flag_mismatch("go delay after fmt_change", `GO_DELAY, cyc - chg_cyc + 1);
			end
			if (de)
				de_count++;
			if (hsync !== hs_last || vsync !== vs_last)
				sync_moves++;
		end
		fac_prev = {pclk_m, pclk_d};
		hs_last = hsync;
		vs_last = vsync;
	end

	// Short random glitches, then settle on hold
	task automatic bounce_sw(input logic [`SW_W-1:0] hold);
		logic [`SW_W-1:0] v;
		int hold_cyc;
		v = sw;
		repeat (BOUNCE_STEPS) begin
			v = v ^ `SW_W'(1 + $urandom % 15); // Always a new value
			sw = v;
			hold_cyc = 1 + $urandom % (`DEBOUNCE_LEN - 3);
			repeat (hold_cyc) @(negedge clk50m_bufg);
		end
		sw = hold;
	endtask

	// Returns on the negedge where the factors first change
	task automatic select_code(input logic [`SW_W-1:0] code);
		logic [2*`DCM_W-1:0] f0;
		int n;
		f0 = {pclk_m, pclk_d};
		n = 0;
		@(negedge clk50m_bufg);
		sw = code;
		while ({pclk_m, pclk_d} === f0 && n < SWITCH_CYC) begin
			@(negedge clk50m_bufg);
			n++;
		end
		if (n >= SWITCH_CYC) begin
			$display("%s: factors did not change after selecting code %b", test_name, code);
			errors++;
		end
	endtask

	task automatic check_factors(input video_fmt_pkg::fmt_sw_t code);
		fmt_ref_t r;
		int g0;
		r = expected_format(code);
		begin_test($sformatf("factors %s", code.name()));
		g0 = go_count;
		select_code(code);
		repeat (SETTLE_CYC) @(negedge clk50m_bufg);
		if (go_count - g0 != 1)
			flag_mismatch("go pulses", 1, go_count - g0);
		if (pclk_m !== r.m - 1)
			flag_mismatch("pclk_m", r.m - 1, pclk_m);
		if (pclk_d !== r.d - 1)
			flag_mismatch("pclk_d", r.d - 1, pclk_d);
		end_test;
	endtask

	////////////////////////////////////////
	// Raster measurement
	////////////////////////////////////////

	// max_lines 0 runs one whole frame up to the next live pixel
	task automatic measure_raster(input video_fmt_pkg::fmt_sw_t code, input int max_lines);
		fmt_ref_t r = expected_format(code);
		int n = 0, hs_start = -1, hs_run = 0, de_run = 0;
		int lines = 0, de_lines = 0, vs_cyc = 0, vs_line = -1, sync_in_de = 0;
		int exp_lines;
		logic hs_act, vs_act;
		logic hs_prev = 1'b0, vs_prev = 1'b0, de_prev = 1'b0;
		bit vs_over = 0;
		bit done = 0;
		exp_lines = (max_lines == 0) ? r.v_live : max_lines + 1; // Live ends before sync
		while (!done) begin
			@(negedge clk50m_bufg);
			n++;
			hs_act = (hsync !== r.neg); // Active level set by polarity
			vs_act = (vsync !== r.neg);
			if (hs_act && !hs_prev) begin
				if (hs_start >= 0 && n - hs_start != r.h_total)
					flag_mismatch("hsync period", r.h_total, n - hs_start);
				hs_start = n;
				lines++;
			end
			if (hs_act) begin
				hs_run++;
			end else if (hs_prev) begin
				if (hs_run != r.h_sync)
					flag_mismatch("hsync width", r.h_sync, hs_run);
				hs_run = 0;
			end
			if (de) begin
				de_run++;
			end else if (de_prev) begin // End of a live line
				if (de_run != r.h_live)
					flag_mismatch("de run length", r.h_live, de_run);
				de_run = 0;
				de_lines++;
			end
			if (vs_act)
				vs_cyc++;
			if (vs_act && !vs_prev)
				vs_line = lines; // Lines begun before vsync
			if (vs_prev && !vs_act)
				vs_over = 1;
			if (de && (hs_act || vs_act))
				sync_in_de++;
			if (max_lines > 0)
				done = (lines > max_lines);
			else
				done = vs_over && de && !de_prev; // First live pixel of the next frame
			hs_prev = hs_act;
			vs_prev = vs_act;
			de_prev = de;
		end
		if (de_lines != exp_lines)
			flag_mismatch("live lines", exp_lines, de_lines);
		if (max_lines == 0) begin
			if (vs_line != r.v_live + r.v_fp)
				flag_mismatch("lines before vsync", r.v_live + r.v_fp, vs_line);
			if (lines != r.v_total)
				flag_mismatch("lines per frame", r.v_total, lines);
			if (vs_cyc != r.v_sync * r.h_total)
				flag_mismatch("vsync width in cycles", r.v_sync * r.h_total, vs_cyc);
		end
		if (sync_in_de != 0)
			flag_mismatch("sync active during de", 0, sync_in_de);
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	initial begin : watchdog
		while (cyc < RUN_LIMIT)
			@(posedge clk50m_bufg);
		$display("Timeout, run stopped after %0d cycles without finishing", cyc);
		$display("Test FAILED");
		$finish;
	end

	initial begin : stimulus
		logic [2*`DCM_W-1:0] f0;
		int g0;
		fmt_ref_t r0;
		void'($urandom(32'h5702_b707));
		RSTBTN = 1'b1;
		sw = '0;
		repeat (5) @(negedge clk50m_bufg);
		RSTBTN = 1'b0;

		begin_test("idle until first setting");
		bounce_sw(video_fmt_pkg::FMT_VGA); // Nothing stable long enough
		r0 = expected_format(video_fmt_pkg::FMT_VGA); // Format held after reset
		if (go_count != 0)
			flag_mismatch("go pulses", 0, go_count);
		if (de_count != 0)
			flag_mismatch("de high cycles", 0, de_count);
		if (sync_moves != 0)
			flag_mismatch("sync level changes", 0, sync_moves);
		if (hsync !== r0.neg)
			flag_mismatch("idle hsync level", r0.neg, hsync);
		if (vsync !== r0.neg)
			flag_mismatch("idle vsync level", r0.neg, vsync);
		end_test;

		check_factors(video_fmt_pkg::FMT_VGA);
		check_factors(video_fmt_pkg::FMT_SVGA);
		check_factors(video_fmt_pkg::FMT_HDTV720P);
		check_factors(video_fmt_pkg::FMT_XGA);
		check_factors(video_fmt_pkg::FMT_SXGA);
		check_factors(video_fmt_pkg::FMT_CAMERA);

		begin_test("bounce rejection");
		f0 = {pclk_m, pclk_d};
		g0 = go_count;
		bounce_sw(video_fmt_pkg::FMT_CAMERA);
		repeat (SWITCH_CYC + SETTLE_CYC) @(negedge clk50m_bufg);
		if (go_count != g0)
			flag_mismatch("go pulses", 0, go_count - g0);
		if ({pclk_m, pclk_d} !== f0)
			flag_mismatch("factors", f0, {pclk_m, pclk_d});
		end_test;

		begin_test("VGA raster");
		select_code(video_fmt_pkg::FMT_VGA);
		measure_raster(video_fmt_pkg::FMT_VGA, 0);
		end_test;

		begin_test("SVGA raster");
		select_code(video_fmt_pkg::FMT_SVGA);
		measure_raster(video_fmt_pkg::FMT_SVGA, 0);
		end_test;

		begin_test("reselect same code");
		g0 = go_count;
		bounce_sw(video_fmt_pkg::FMT_SVGA);
		repeat (SWITCH_CYC + SETTLE_CYC) @(negedge clk50m_bufg);
		if (go_count != g0)
			flag_mismatch("go pulses", 0, go_count - g0);
		end_test;

		begin_test("undefined code");
		select_code(4'b0101); // Falls back to 720p
		measure_raster(video_fmt_pkg::fmt_sw_t'(4'b0101), 3);
		if (pclk_m !== 8'd247)
			flag_mismatch("pclk_m", 247, pclk_m);
		if (pclk_d !== 8'd166)
			flag_mismatch("pclk_d", 166, pclk_d);
		end_test;

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hw
hw/video_fmt_pkg.sv
hw/pclk_cfg_pkg.sv
hw/sw_debounce.sv
hw/pclk_ratio_sel.sv
hw/video_timing_sel.sv
hw/timing_gen.sv
hw/dvi_fmt_ctrl.sv
tests/tb_dvi_fmt_ctrl.sv

/* Bender.yml */
package:
  name: dvi_fmt_ctrl

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/video_fmt_pkg.sv
      - hw/pclk_cfg_pkg.sv
      - hw/sw_debounce.sv
      - hw/pclk_ratio_sel.sv
      - hw/video_timing_sel.sv
      - hw/timing_gen.sv
      - hw/dvi_fmt_ctrl.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/tb_dvi_fmt_ctrl.sv
